// ==== rtl/af_pkg.sv ====
// Analog front end package with widths, sample types and register map

package af_pkg;

  //////////////////////////////////////////////////
  // Datapath widths and sample types
  //////////////////////////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;   // Raw ADC pin word
  localparam int unsigned SMP_W     = 14;   // Converted sample

  typedef logic        [ADC_RAW_W-1:0] raw_t;       // Unsigned, negative slope
  typedef logic signed [SMP_W-1:0]     sample_t;    // Two's complement
  typedef logic        [SMP_W-1:0]     dac_word_t;  // Offset, negative slope

  //////////////////////////////////////////////////
  // System bus
  //////////////////////////////////////////////////

  localparam int unsigned SYS_AW = 20;
  localparam int unsigned SYS_DW = 32;

  typedef logic [SYS_AW-1:0] sys_addr_t;
  typedef logic [SYS_DW-1:0] sys_data_t;

  // Register byte offsets
  localparam sys_addr_t REG_ID   = 20'h00000;
  localparam sys_addr_t REG_CTRL = 20'h00004;
  localparam sys_addr_t REG_STAT = 20'h00008;

  // Control register bits
  localparam int unsigned CTRL_LOOP = 0;  // Digital loopback
  localparam int unsigned CTRL_AVG  = 1;  // Channel A averaging

  // Design identification word
  localparam sys_data_t AF_ID = 32'hAF01_0001;

endpackage : af_pkg

// ==== rtl/adc_frontend.sv ====
// ADC input registers with negative slope conversion and loopback select
`timescale 1ns/100ps

module adc_frontend (
  input  logic            adc_clk,
  input  logic            adc_rstn,
  input  af_pkg::raw_t    adc_a_i,
  input  af_pkg::raw_t    adc_b_i,
  input  logic            loop_i,     // Replace ADC with mix
  input  af_pkg::sample_t sum_a_i,
  input  af_pkg::sample_t sum_b_i,
  output af_pkg::sample_t adc_a_o,
  output af_pkg::sample_t adc_b_o
);

  import af_pkg::*;

  logic [SMP_W-1:0] raw_a_q, raw_b_q;   // Upper bits of the pin words
  sample_t          cnv_a, cnv_b;       // Two's complement samples

  // Input registers, two low bits reserved on the 16 bit bus
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_a_i[ADC_RAW_W-1 -: SMP_W];
      raw_b_q <= adc_b_i[ADC_RAW_W-1 -: SMP_W];
    end
  end

  // Negative slope to two's complement
  // MSB kept, magnitude bits inverted
  assign cnv_a = sample_t'({raw_a_q[SMP_W-1], ~raw_a_q[SMP_W-2:0]});
  assign cnv_b = sample_t'({raw_b_q[SMP_W-1], ~raw_b_q[SMP_W-2:0]});

  // Loopback bypasses the ADC registers
  assign adc_a_o = loop_i ? sum_a_i : cnv_a;
  assign adc_b_o = loop_i ? sum_b_i : cnv_b;

endmodule : adc_frontend

// ==== rtl/dac_mixer.sv ====
// Generator plus feedback adder with 14 bit saturation per channel
`timescale 1ns/100ps

module dac_mixer (
  input  af_pkg::sample_t gen_a_i,
  input  af_pkg::sample_t gen_b_i,
  input  af_pkg::sample_t fb_a_i,
  input  af_pkg::sample_t fb_b_i,
  output af_pkg::sample_t sum_a_o,
  output af_pkg::sample_t sum_b_o,
  output logic            clamp_a_o,  // High while A saturates
  output logic            clamp_b_o   // High while B saturates
);

  import af_pkg::*;

  // Saturation limits, 8191 and -8192
  localparam sample_t SMP_MAX = sample_t'((1 << (SMP_W-1)) - 1);
  localparam sample_t SMP_MIN = ~SMP_MAX;

  logic signed [SMP_W:0] wide_a, wide_b;  // One guard bit

  //////////////////////////////////////////////////
  // Full precision sums
  //////////////////////////////////////////////////

  assign wide_a = gen_a_i + fb_a_i;   // Signed operands extend
  assign wide_b = gen_b_i + fb_b_i;

  //////////////////////////////////////////////////
  // Overflow detect and clamp
  //////////////////////////////////////////////////

  // Guard bit differs from sign bit on overflow
  assign clamp_a_o = wide_a[SMP_W] ^ wide_a[SMP_W-1];
  assign clamp_b_o = wide_b[SMP_W] ^ wide_b[SMP_W-1];

  always_comb begin
    if (clamp_a_o) begin
      sum_a_o = wide_a[SMP_W] ? SMP_MIN : SMP_MAX;  // Sign of true sum
    end else begin
      sum_a_o = wide_a[SMP_W-1:0];
    end
    if (clamp_b_o) begin
      sum_b_o = wide_b[SMP_W] ? SMP_MIN : SMP_MAX;
    end else begin
      sum_b_o = wide_b[SMP_W-1:0];
    end
  end

endmodule : dac_mixer

// ==== rtl/dac_avg_filter.sv ====
// Moving average over a power of two window using a running sum
`timescale 1ns/100ps

module dac_avg_filter #(
  parameter int unsigned AVG_LOG2 = 6   // Window of 2^AVG_LOG2 samples
)(
  input  logic            adc_clk,
  input  logic            adc_rstn,
  input  af_pkg::sample_t smp_i,
  output af_pkg::sample_t avg_o
);

  import af_pkg::*;

  localparam int unsigned DEPTH = 1 << AVG_LOG2;
  localparam int unsigned SUM_W = SMP_W + AVG_LOG2;   // Room for full window

  sample_t                 hist [DEPTH];  // Sample ring
  logic [AVG_LOG2-1:0]     wr_ptr;        // Oldest entry, overwritten next
  logic                    full_q;        // Ring holds a whole window
  sample_t                 oldest;
  logic signed [SUM_W-1:0] smp_ext, old_ext;
  logic signed [SUM_W-1:0] sum_q;
  logic signed [SUM_W-1:0] sum_shr;

  //////////////////////////////////////////////////
  // History ring
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    hist[wr_ptr] <= smp_i;
  end

  // Entries not yet written count as zero
  assign oldest  = full_q ? hist[wr_ptr] : sample_t'(0);
  assign smp_ext = smp_i;     // Sign extended
  assign old_ext = oldest;

  //////////////////////////////////////////////////
  // Running sum
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      wr_ptr <= '0;
      full_q <= 1'b0;
      sum_q  <= '0;
    end else begin
      wr_ptr <= wr_ptr + 1'b1;                       // Wraps at DEPTH
      sum_q  <= sum_q + smp_ext - old_ext;           // New in, oldest out
      if (wr_ptr == AVG_LOG2'(DEPTH - 1)) begin
        full_q <= 1'b1;
      end
    end
  end

  // Floor division by the window length
  assign sum_shr = sum_q >>> AVG_LOG2;
  assign avg_o   = sum_shr[SMP_W-1:0];   // Mean always fits a sample

endmodule : dac_avg_filter

// ==== rtl/dac_output.sv ====
// DAC output registers with filter bypass and offset negative slope format
`timescale 1ns/100ps

module dac_output (
  input  logic              adc_clk,
  input  logic              adc_rstn,
  input  logic              avg_i,      // Use filtered channel A
  input  af_pkg::sample_t   sum_a_i,    // Channel A direct mix
  input  af_pkg::sample_t   avg_a_i,    // Channel A averaged
  input  af_pkg::sample_t   sum_b_i,
  output af_pkg::dac_word_t dac_a_o,
  output af_pkg::dac_word_t dac_b_o
);

  import af_pkg::*;

  sample_t dac_a_sel;

  //////////////////////////////////////////////////
  // Channel A source select
  //////////////////////////////////////////////////

  assign dac_a_sel = avg_i ? avg_a_i : sum_a_i;

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  // Two's complement to offset with negative slope
  // Sign kept, lower bits inverted
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end else begin
      dac_a_o <= {dac_a_sel[SMP_W-1], ~dac_a_sel[SMP_W-2:0]};
      dac_b_o <= {sum_b_i[SMP_W-1], ~sum_b_i[SMP_W-2:0]};    // Never filtered
    end
  end

endmodule : dac_output

// ==== rtl/af_regs.sv ====
// Register block with ID, control bits and sticky saturation status
`timescale 1ns/100ps

module af_regs (
  input  logic              adc_clk,
  input  logic              adc_rstn,
  // System bus
  input  af_pkg::sys_addr_t sys_addr_i,
  input  af_pkg::sys_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  // Saturation levels from the mixer
  input  logic              clamp_a_i,
  input  logic              clamp_b_i,
  output af_pkg::sys_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // Control levels
  output logic              loop_o,
  output logic              avg_o
);

  import af_pkg::*;

  localparam int unsigned STAT_W = 2;   // Bit 0 channel A, bit 1 channel B

  logic              hit_id, hit_ctrl, hit_stat;
  logic              strobe;             // Any bus access
  logic [STAT_W-1:0] stat_q;             // Sticky clamp flags
  logic [STAT_W-1:0] stat_clr;           // Write one to clear
  sys_data_t         ctrl_word;
  sys_data_t         stat_word;
  sys_data_t         rdata_d;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign hit_id   = (sys_addr_i == REG_ID  );
  assign hit_ctrl = (sys_addr_i == REG_CTRL);
  assign hit_stat = (sys_addr_i == REG_STAT);
  assign strobe   = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////
  // Control and status registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      loop_o <= 1'b0;
      avg_o  <= 1'b0;
    end else if (sys_wen_i && hit_ctrl) begin
      loop_o <= sys_wdata_i[CTRL_LOOP];
      avg_o  <= sys_wdata_i[CTRL_AVG];
    end
  end

  assign stat_clr = (sys_wen_i && hit_stat) ? sys_wdata_i[STAT_W-1:0] : '0;

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      stat_q <= '0;
    end else begin
      stat_q <= (stat_q & ~stat_clr) | {clamp_b_i, clamp_a_i};  // Set beats clear
    end
  end

  //////////////////////////////////////////////////
  // Read mux and bus response
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_word            = '0;
    ctrl_word[CTRL_LOOP] = loop_o;
    ctrl_word[CTRL_AVG]  = avg_o;
    stat_word             = '0;
    stat_word[STAT_W-1:0] = stat_q;
    unique case (1'b1)
      hit_id:   rdata_d = AF_ID;
      hit_ctrl: rdata_d = ctrl_word;
      hit_stat: rdata_d = stat_word;
      default:  rdata_d = '0;       // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rdata_d;       // Valid with the ack
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      sys_ack_o <= strobe;                                        // One cycle after strobe
      sys_err_o <= strobe && !(hit_id || hit_ctrl || hit_stat);   // Unmapped address
    end
  end

endmodule : af_regs

// ==== rtl/af_top.sv ====
// Analog front end top level connecting ADC, mixer, filter, DAC and registers
`timescale 1ns/100ps

module af_top #(
  parameter int unsigned AVG_LOG2 = 6   // Filter window is 2^AVG_LOG2
)(
  input  logic              adc_clk,
  input  logic              adc_rstn,
  // ADC pins
  input  af_pkg::raw_t      adc_a_i,
  input  af_pkg::raw_t      adc_b_i,
  // Generator and feedback samples
  input  af_pkg::sample_t   gen_a_i,
  input  af_pkg::sample_t   gen_b_i,
  input  af_pkg::sample_t   fb_a_i,
  input  af_pkg::sample_t   fb_b_i,
  // Converted ADC samples
  output af_pkg::sample_t   adc_a_o,
  output af_pkg::sample_t   adc_b_o,
  // DAC pins
  output af_pkg::dac_word_t dac_a_o,
  output af_pkg::dac_word_t dac_b_o,
  // System bus
  input  af_pkg::sys_addr_t sys_addr_i,
  input  af_pkg::sys_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output af_pkg::sys_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o
);

  import af_pkg::*;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  logic    loop;              // Loopback enable
  logic    avg;               // Averaging enable
  sample_t sum_a, sum_b;      // Saturated mix
  logic    clamp_a, clamp_b;  // Saturation levels
  sample_t avg_a;             // Filtered channel A

  //////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////

  af_regs i_regs (
    .adc_clk     (adc_clk    ),
    .adc_rstn    (adc_rstn   ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .clamp_a_i   (clamp_a    ),
    .clamp_b_i   (clamp_b    ),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o  ),
    .sys_err_o   (sys_err_o  ),
    .loop_o      (loop       ),
    .avg_o       (avg        )
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .adc_a_i  (adc_a_i ),
    .adc_b_i  (adc_b_i ),
    .loop_i   (loop    ),
    .sum_a_i  (sum_a   ),   // Loopback source
    .sum_b_i  (sum_b   ),
    .adc_a_o  (adc_a_o ),
    .adc_b_o  (adc_b_o )
  );

  dac_mixer i_mix (
    .gen_a_i   (gen_a_i),
    .gen_b_i   (gen_b_i),
    .fb_a_i    (fb_a_i ),
    .fb_b_i    (fb_b_i ),
    .sum_a_o   (sum_a  ),
    .sum_b_o   (sum_b  ),
    .clamp_a_o (clamp_a),
    .clamp_b_o (clamp_b)
  );

  dac_avg_filter #(.AVG_LOG2 (AVG_LOG2)) i_avg (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .smp_i    (sum_a   ),   // Channel A only
    .avg_o    (avg_a   )
  );

  dac_output i_dac (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .avg_i    (avg     ),
    .sum_a_i  (sum_a   ),
    .avg_a_i  (avg_a   ),
    .sum_b_i  (sum_b   ),
    .dac_a_o  (dac_a_o ),
    .dac_b_o  (dac_b_o )
  );

endmodule : af_top

// ==== test/tb_af_checks.svh ====
// Compare tasks and bus access tasks for the analog front end testbench
`ifndef TB_AF_CHECKS_SVH
`define TB_AF_CHECKS_SVH

localparam int ACK_MAX = 8;   // Cycles before a lost ack is declared

// Step to the drive point after the next rising edge
task automatic next_cycle();
  @(posedge adc_clk);
  #(DRIVE_NS);
endtask

//////////////////////////////////////////////////
// Compare tasks, one per result type
//////////////////////////////////////////////////

task automatic check_sample(input string name, input sample_t act, input sample_t want);
  if (act !== want) begin
    err_cnt++;
    $display("error %s: got 0x%h, expected 0x%h at %0t", name, act, want, $time);
  end
endtask

task automatic check_dac(input string name, input dac_word_t act, input dac_word_t want);
  if (act !== want) begin
    err_cnt++;
    $display("error %s: got 0x%h, expected 0x%h at %0t", name, act, want, $time);
  end
endtask

task automatic check_data(input string name, input sys_data_t act, input sys_data_t want);
  if (act !== want) begin
    err_cnt++;
    $display("error %s: got 0x%h, expected 0x%h at %0t", name, act, want, $time);
  end
endtask

task automatic check_flag(input string name, input logic act, input logic want);
  if (act !== want) begin
    err_cnt++;
    $display("error %s: got 0x%h, expected 0x%h at %0t", name, act, want, $time);
  end
endtask

//////////////////////////////////////////////////
// Bus access
//////////////////////////////////////////////////

// One strobe, then wait for the ack
task automatic bus_access(input logic wr, input sys_addr_t addr, input sys_data_t wdata,
                          output sys_data_t rdata, output logic err);
  int lat;
  sys_addr_i  = addr;
  sys_wdata_i = wdata;
  sys_wen_i   = wr;
  sys_ren_i   = !wr;
  next_cycle();
  sys_wen_i = 1'b0;
  sys_ren_i = 1'b0;
  lat = 1;
  while (!sys_ack_o && lat < ACK_MAX) begin
    next_cycle();
    lat++;
  end
  if (!sys_ack_o) begin
    err_cnt++;
    $display("bus access to 0x%h was never acknowledged", addr);
  end else if (lat != 1) begin
    err_cnt++;
    $display("bus ack came %0d cycles after the strobe instead of 1", lat);
  end
  rdata = sys_rdata_o;   // Only meaningful for reads
  err   = sys_err_o;
endtask

`endif

// ==== test/tb_af_top.sv ====
// Testbench for the analog front end with a reference model and per cycle checks
`timescale 1ns/100ps

module tb_af_top;

  import af_pkg::*;

  localparam int AVG_LOG2  = 6;
  localparam int AVG_N     = 1 << AVG_LOG2;
  localparam int SMP_MAX_I = (1 << (SMP_W - 1)) - 1;   // 8191
  localparam int CLK_NS    = 4;
  localparam int DRIVE_NS  = 1;                        // Input skew after the edge
  localparam int RST_CYC   = 5;
  // Cycles per test in sequence order plus the first reset
  localparam int TEST_CYC  = 40 + 210 + 240 + (RST_CYC + 320) + 130 + RST_CYC;
  localparam int WDOG_NS   = 2 * TEST_CYC * CLK_NS;
  localparam sample_t MAX_SMP = sample_t'(SMP_MAX_I);
  localparam sample_t MIN_SMP = sample_t'(-SMP_MAX_I - 1);

  logic      adc_clk, adc_rstn;
  raw_t      adc_a_i, adc_b_i;
  sample_t   gen_a_i, gen_b_i, fb_a_i, fb_b_i;
  sample_t   adc_a_o, adc_b_o;
  dac_word_t dac_a_o, dac_b_o;
  sys_addr_t sys_addr_i;
  sys_data_t sys_wdata_i, sys_rdata_o;
  logic      sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;

  sample_t   hist_mdl [AVG_N];       // Model history ring
  int        hist_ptr;
  sample_t   exp_adc_a, exp_adc_b;   // Registered ADC expectation
  dac_word_t exp_dac_a, exp_dac_b;
  dac_word_t avg_pend;               // Window mean due one edge later
  logic      exp_ack;                // Strobe seen at the last edge
  logic      loop_mode, avg_mode;    // Control bits as written
  logic      chk_en;
  integer    seed;
  int        err_cnt, err_mark, test_cnt, fail_cnt;
  sys_data_t rd;
  logic      rd_err;

  `include "tb_af_checks.svh"

  af_top #(.AVG_LOG2 (AVG_LOG2)) UUT (.*);

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_NS / 2) adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Top of the negative slope code range is the most negative value
  function automatic sample_t adc_conv(input raw_t r);
    return sample_t'(SMP_MAX_I - int'(r >> (ADC_RAW_W - SMP_W)));
  endfunction

  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > SMP_MAX_I) s = SMP_MAX_I;
    if (s < -SMP_MAX_I - 1) s = -SMP_MAX_I - 1;
    return sample_t'(s);
  endfunction

  function automatic dac_word_t to_offset(input sample_t s);
    return dac_word_t'(SMP_MAX_I - int'(s));   // Offset binary with reversed slope
  endfunction

  // With filt set the mix enters the history and the mean comes back
  function automatic dac_word_t ref_dac(input sample_t gen, input sample_t fb,
                                        input bit filt);
    sample_t mix;
    int      sum;
    int      q;
    mix = sat_sum(gen, fb);
    if (!filt) return to_offset(mix);
    hist_mdl[hist_ptr] = mix;
    hist_ptr = (hist_ptr + 1) % AVG_N;
    sum = 0;
    foreach (hist_mdl[k]) sum += int'(hist_mdl[k]);
    q = sum / AVG_N;
    if (sum < 0 && sum % AVG_N != 0) q = q - 1;   // Floor rather than truncation
    return to_offset(sample_t'(q));
  endfunction

  always @(posedge adc_clk) begin
    if (!adc_rstn) begin
      foreach (hist_mdl[k]) hist_mdl[k] = '0;
      hist_ptr  = 0;
      exp_adc_a = adc_conv('0);
      exp_adc_b = adc_conv('0);
      exp_dac_a = '0;
      exp_dac_b = '0;
      avg_pend  = to_offset('0);   // Empty window
      exp_ack   = 1'b0;
    end else begin
      exp_adc_a = adc_conv(adc_a_i);
      exp_adc_b = adc_conv(adc_b_i);
      exp_dac_a = avg_mode ? avg_pend : ref_dac(gen_a_i, fb_a_i, 1'b0);
      avg_pend  = ref_dac(gen_a_i, fb_a_i, 1'b1);   // Filter runs in every mode
      exp_dac_b = ref_dac(gen_b_i, fb_b_i, 1'b0);
      exp_ack   = sys_wen_i | sys_ren_i;            // Ack pulse follows each strobe
    end
  end

  // Compare at the falling edge away from input and register updates
  always @(negedge adc_clk) begin
    if (chk_en) begin
      check_sample("adc_a_o", adc_a_o, loop_mode ? sat_sum(gen_a_i, fb_a_i) : exp_adc_a);
      check_sample("adc_b_o", adc_b_o, loop_mode ? sat_sum(gen_b_i, fb_b_i) : exp_adc_b);
      check_dac("dac_a_o", dac_a_o, exp_dac_a);
      check_dac("dac_b_o", dac_b_o, exp_dac_b);
      check_flag("sys_ack_o", sys_ack_o, exp_ack);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic apply_reset();
    chk_en    = 1'b0;
    adc_rstn  = 1'b0;
    loop_mode = 1'b0;
    avg_mode  = 1'b0;
    repeat (RST_CYC) next_cycle();
    adc_rstn = 1'b1;
    chk_en   = 1'b1;
  endtask

  task automatic set_ctrl(input logic loop, input logic avg);
    sys_data_t w;
    logic      e;
    w            = '0;
    w[CTRL_LOOP] = loop;
    w[CTRL_AVG]  = avg;
    bus_access(1'b1, REG_CTRL, w, rd, e);
    check_flag("sys_err_o", e, 1'b0);
    loop_mode = loop;   // DUT bit moved at the ack edge
    avg_mode  = avg;
  endtask

  task automatic drive_mix(input sample_t ga, input sample_t fa,
                           input sample_t gb, input sample_t fbb);
    gen_a_i = ga;
    fb_a_i  = fa;
    gen_b_i = gb;
    fb_b_i  = fbb;
  endtask

  task automatic drive_random_mix();
    drive_mix(sample_t'($random(seed)), sample_t'($random(seed)),
              sample_t'($random(seed)), sample_t'($random(seed)));
  endtask

  task automatic finish_test(input string name);
    int errs;
    next_cycle();   // Last driven edge gets compared first
    errs = err_cnt - err_mark;
    test_cnt++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, errs);
    end
    err_mark = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    {adc_a_i, adc_b_i} = '0;
    {gen_a_i, gen_b_i, fb_a_i, fb_b_i} = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    seed        = 91;
    {err_cnt, err_mark, test_cnt, fail_cnt} = '0;
    apply_reset();

    // Register map, ack and error response
    bus_access(1'b0, REG_ID, '0, rd, rd_err);
    check_data("sys_rdata_o", rd, AF_ID);
    check_flag("sys_err_o", rd_err, 1'b0);
    set_ctrl(1'b1, 1'b1);
    bus_access(1'b0, REG_CTRL, '0, rd, rd_err);
    check_data("sys_rdata_o", rd, sys_data_t'((1 << CTRL_LOOP) | (1 << CTRL_AVG)));
    set_ctrl(1'b0, 1'b0);
    bus_access(1'b0, 20'h0000C, '0, rd, rd_err);
    check_flag("sys_err_o", rd_err, 1'b1);
    bus_access(1'b1, REG_ID, 32'h1234_5678, rd, rd_err);   // Read only
    bus_access(1'b0, REG_ID, '0, rd, rd_err);
    check_data("sys_rdata_o", rd, AF_ID);
    finish_test("register bus");

    for (int i = 0; i < 200; i++) begin
      adc_a_i = raw_t'($random(seed));
      adc_b_i = raw_t'($random(seed));
      next_cycle();
    end
    finish_test("ADC conversion");

    // Random mix with forced extremes every tenth cycle
    for (int i = 0; i < 200; i++) begin
      drive_random_mix();
      if (i % 10 == 0) begin
        case ((i / 10) % 4)
          0:       drive_mix(MAX_SMP, MAX_SMP, MIN_SMP, MIN_SMP);
          1:       drive_mix(MIN_SMP, sample_t'(-1), MAX_SMP, sample_t'(1));
          2:       drive_mix(MAX_SMP, MIN_SMP, MIN_SMP, MAX_SMP);   // Sum of -1 without clamp
          default: drive_mix(MAX_SMP, '0, '0, MIN_SMP);             // Exact limits
        endcase
      end
      next_cycle();
    end
    drive_mix('0, '0, '0, '0);
    bus_access(1'b1, REG_STAT, 32'h3, rd, rd_err);   // Drop earlier flags
    drive_mix(MAX_SMP, sample_t'(1), '0, '0);         // A alone
    next_cycle();
    drive_mix('0, '0, '0, '0);
    bus_access(1'b0, REG_STAT, '0, rd, rd_err);
    check_data("sys_rdata_o", rd, 32'h1);
    drive_mix('0, '0, MIN_SMP, sample_t'(-1));        // B alone
    next_cycle();
    drive_mix('0, '0, '0, '0);
    bus_access(1'b1, REG_STAT, 32'h1, rd, rd_err);
    bus_access(1'b0, REG_STAT, '0, rd, rd_err);
    check_data("sys_rdata_o", rd, 32'h2);
    bus_access(1'b1, REG_STAT, 32'h2, rd, rd_err);
    bus_access(1'b0, REG_STAT, '0, rd, rd_err);
    check_data("sys_rdata_o", rd, 32'h0);
    finish_test("mixer and DAC");

    apply_reset();   // Empty filter history
    set_ctrl(1'b0, 1'b1);
    for (int i = 0; i < 300; i++) begin
      drive_random_mix();
      next_cycle();
    end
    finish_test("moving average");

    set_ctrl(1'b1, 1'b0);
    for (int i = 0; i < 120; i++) begin
      drive_random_mix();
      adc_a_i = raw_t'($random(seed));
      adc_b_i = raw_t'($random(seed));
      if (i == 100) set_ctrl(1'b0, 1'b0);   // Back to ADC data
      next_cycle();
    end
    finish_test("digital loopback");

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WDOG_NS);
    $display("watchdog expired after %0d ns, the test sequence did not finish", WDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_af_top

// ==== src.f ====
+incdir+test
rtl/af_pkg.sv
rtl/adc_frontend.sv
rtl/dac_mixer.sv
rtl/dac_avg_filter.sv
rtl/dac_output.sv
rtl/af_regs.sv
rtl/af_top.sv
test/tb_af_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the analog front end testbench with Verilator and run it.
# The result is read from the simulator output, with no log file.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_af_top -f src.f -o tb_af_top \
  && ./obj_dir/tb_af_top | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
